// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide on the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps --top-module tb_rv_exec \
   -f sources.f -o tb_rv_exec &&
./obj_dir/tb_rv_exec | tee /dev/stderr | grep -qx "PASS: all tests" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: sim/tb_clock.sv
// free-running testbench clock, 10 ns period, starts low at time zero
`timescale 1ns/100ps

module tb_clock (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
      forever begin
         #5 o_clk = ~o_clk; // half period
      end
   end

endmodule

// File: sim/tb_rv_exec.sv
// testbench for rv_exec_top; registers start unknown, so test 1 must load all of them first
`timescale 1ns/100ps

module tb_rv_exec;
   import rv_pkg::*;

   typedef struct packed {
      logic [31:0] issued; // cycle count at issue
      wb_t wb;
   } expect_t;

   logic clk;
   logic rst;
   logic valid;
   inst_t inst;
   wb_t wb;

   logic [31:0] cycle = '0;
   logic checking = 1'b0;
   int errors = 0;
   int checks = 0;
   int tests = 0;
   int errors_before = 0;
   word_t model_regs [NREGS];
   wb_t pend [3]; // model writes in flight, newest first
   expect_t exp_q [$];

   tb_clock i_tb_clock (.o_clk(clk));

   rv_exec_top i_rv_exec_top (
      .i_clk   (clk),
      .i_rst   (rst),
      .i_valid (valid),
      .i_inst  (inst),
      .o_wb    (wb)
   );

   always @(posedge clk) cycle <= cycle + 32'd1;

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      checks++;
      if (got !== expected) begin
         $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, expected);
         errors++;
      end
   endtask

   function automatic inst_t make_rtype(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                        logic [2:0] f3, reg_addr_t rd);
      return {f7, rs2, rs1, f3, rd, OPC_OP, 2'b11};
   endfunction

   function automatic inst_t make_itype(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                        reg_addr_t rd);
      return {imm, rs1, f3, rd, OPC_OPIMM, 2'b11};
   endfunction

   function automatic inst_t make_lui(logic [19:0] imm, reg_addr_t rd);
      return {imm, rd, OPC_LUI, 2'b11};
   endfunction

   // plain 32-bit arithmetic, no half splitting
   function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
      word_t res;
      case (f3)
         3'd0: res = alt ? a - b : a + b;
         3'd1: res = a << b[4:0];
         3'd2: res = {31'b0, $signed(a) < $signed(b)};
         3'd3: res = {31'b0, a < b};
         3'd4: res = a ^ b;
         3'd5: begin
            if (alt)
               res = $signed(a) >>> b[4:0];
            else
               res = a >> b[4:0];
         end
         3'd6: res = a | b;
         default: res = a & b;
      endcase
      return res;
   endfunction

   function automatic wb_t ref_result(inst_t ins);
      wb_t r;
      logic [2:0] f3;
      logic [6:0] f7;
      word_t a;
      word_t b;
      f3 = ins[14:12];
      f7 = ins[31:25];
      a = model_regs[ins[19:15]];
      b = model_regs[ins[24:20]];
      r = '0;
      r.valid = 1'b1;
      r.rd = ins[11:7];
      if (ins[6:0] == {OPC_LUI, 2'b11}) begin
         r.data = {ins[31:12], 12'b0};
      end else if (ins[6:0] == {OPC_OP, 2'b11}) begin
         r.illegal = !((f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5)));
         r.data = alu_ref(f3, f7 == 7'h20, a, b);
      end else if (ins[6:0] == {OPC_OPIMM, 2'b11}) begin
         b = {{20{ins[31]}}, ins[31:20]};
         if (f3 == 3'd1)
            r.illegal = (f7 != 7'h00);
         if (f3 == 3'd5)
            r.illegal = (f7 != 7'h00) && (f7 != 7'h20);
         r.data = alu_ref(f3, (f3 == 3'd5) && (f7 == 7'h20), a, b);
      end else begin
         r.illegal = 1'b1; // outside the slice
      end
      return r;
   endfunction

   // one issue slot, driven on the falling edge
   task automatic issue(input logic v, input inst_t ins);
      wb_t r;
      expect_t e;
      @(negedge clk);
      // write from three slots back becomes visible now
      if (pend[2].valid && !pend[2].illegal && pend[2].rd != '0)
         model_regs[pend[2].rd] = pend[2].data;
      r = ref_result(ins);
      r.valid = v;
      pend[2] = pend[1];
      pend[1] = pend[0];
      pend[0] = r;
      valid = v;
      inst = ins;
      if (v) begin
         e.issued = cycle;
         e.wb = r;
         exp_q.push_back(e);
      end
   endtask

   task automatic idle(input int n);
      repeat (n) issue(1'b0, '0);
   endtask

   task automatic drain(input string name);
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < 20) begin
         idle(1);
         waited++;
      end
      if (exp_q.size() != 0) begin
         $display("ERROR: %s timed out with %0d writebacks outstanding", name, exp_q.size());
         errors++;
         exp_q.delete();
      end
   endtask

   task automatic finish_test(input string name);
      drain(name);
      tests++;
      $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
      errors_before = errors;
   endtask

   // lui then addi, upper part rounded for the sign of the low 12 bits
   task automatic load_reg(input reg_addr_t rd, input word_t value);
      logic [19:0] upper;
      upper = value[31:12] + 20'(value[11]);
      issue(1'b1, make_lui(upper, rd));
      idle(2);
      issue(1'b1, make_itype(value[11:0], rd, 3'd0, rd));
      idle(2);
   endtask

   // half the picks hit x1..x4 with their shared high half
   function automatic reg_addr_t pick_reg();
      if ($urandom_range(0, 1) == 0)
         return 5'($urandom_range(1, 4));
      return 5'($urandom_range(0, 31));
   endfunction

   always @(negedge clk) begin
      expect_t head;
      if (checking) begin
         if (wb.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
               $display("ERROR at %0t: writeback to x%0d with nothing issued", $time, wb.rd);
               errors++;
            end else begin
               head = exp_q.pop_front();
               check_value("o_wb latency", cycle - head.issued, 32'd3);
               check_value("o_wb.illegal", 32'(wb.illegal), 32'(head.wb.illegal));
               check_value("o_wb.rd", 32'(wb.rd), 32'(head.wb.rd));
               if (!head.wb.illegal)
                  check_value("o_wb.data", wb.data, head.wb.data);
            end
         end else if (wb.valid !== 1'b0) begin
            $display("ERROR at %0t: o_wb.valid is unknown", $time);
            errors++;
         end else if (exp_q.size() != 0 && (cycle - exp_q[0].issued) >= 32'd3) begin
            $display("ERROR at %0t: no writeback for the instruction issued in cycle %0d",
                     $time, exp_q[0].issued);
            errors++;
            void'(exp_q.pop_front());
         end
      end
   end

   initial begin
      word_t value;
      logic [2:0] f3;
      logic [6:0] f7;
      logic [11:0] imm;
      logic [15:0] hi;
      void'($urandom(41));
      rst = 1'b1;
      valid = 1'b0;
      inst = '0;
      for (int i = 0; i < NREGS; i++)
         model_regs[i] = '0;
      for (int i = 0; i < 3; i++)
         pend[i] = '0;
      repeat (10) @(negedge clk);
      rst = 1'b0;
      checking = 1'b1;

      for (int n = 0; n < 8; n++) begin
         idle(1); // nothing may come out yet
         check_value("o_wb.illegal", 32'(wb.illegal), 32'd0);
      end
      for (int r = 1; r < NREGS; r++)
         load_reg(5'(r), $urandom());
      finish_test("reset and register load");

      hi = 16'($urandom()) | 16'h8000; // negative, shared by x1..x4
      for (int r = 1; r <= 4; r++)
         load_reg(5'(r), {hi, 16'($urandom())});
      for (int n = 0; n < 60; n++) begin
         f3 = 3'($urandom_range(0, 7));
         f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
         issue(1'b1, make_rtype(f7, pick_reg(), pick_reg(), f3, 5'($urandom_range(5, 31))));
         idle(2);
      end
      finish_test("random register ops");

      for (int n = 0; n < 60; n++) begin
         f3 = 3'($urandom_range(0, 7));
         imm = 12'($urandom());
         if (f3 == 3'd1 || f3 == 3'd5) begin
            // shift amounts alternate below and above 16
            imm[4:0] = (n % 2 == 0) ? 5'($urandom_range(0, 15)) : 5'($urandom_range(16, 31));
            imm[11:5] = (f3 == 3'd5 && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
         end
         issue(1'b1, make_itype(imm, pick_reg(), f3, 5'($urandom_range(5, 31))));
         idle(2);
      end
      finish_test("random immediate ops");

      for (int d = 1; d <= 4; d++) begin
         issue(1'b1, make_itype(12'($urandom()), 5'd0, 3'd0, 5'(10 + d)));
         for (int k = 1; k < d; k++)
            issue(1'b1, make_itype(12'(d), 5'd0, 3'd0, 5'd30)); // filler
         issue(1'b1, make_rtype(7'h00, 5'd0, 5'(10 + d), 3'd0, 5'(20 + d)));
         drain("dependency distance");
      end
      finish_test("back-to-back dependencies");

      issue(1'b1, make_lui(20'($urandom()), 5'd0));
      issue(1'b1, make_rtype(7'h00, 5'd0, 5'd0, 3'd0, 5'd5)); // x0 read right after
      idle(1);
      issue(1'b1, make_rtype(7'h00, 5'd0, 5'd0, 3'd0, 5'd6));
      value = $urandom();
      issue(1'b1, {value[31:7], 7'b0000011}); // load
      issue(1'b1, {value[31:7], 7'b1100011}); // branch
      issue(1'b1, make_rtype(7'h01, 5'd1, 5'd2, 3'd0, 5'd7));
      issue(1'b1, make_rtype(7'h20, 5'd1, 5'd2, 3'd1, 5'd8));
      issue(1'b1, make_itype({7'h20, 5'd3}, 5'd2, 3'd1, 5'd9));
      issue(1'b1, make_itype({7'h10, 5'd3}, 5'd2, 3'd5, 5'd10));
      for (int r = 1; r < NREGS; r++)
         issue(1'b1, make_itype(12'd0, 5'(r), 3'd0, 5'(r))); // read back
      finish_test("x0 and illegal encodings");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: sources.f
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/stage_delay.sv
verilog/rv_exec_top.sv
sim/tb_clock.sv
sim/tb_rv_exec.sv

// File: verilog/rv_alu.sv
// two-stage ALU, operands registered then results; shifts and compares split in 16-bit halves
`timescale 1ns/100ps

module rv_alu (
   input  logic             i_clk,
   input  rv_pkg::word_t    i_op1,
   input  rv_pkg::word_t    i_op2,
   input  rv_pkg::alu_req_t i_req,
   output rv_pkg::word_t    o_result
);
   import rv_pkg::*;

   // stage one
   word_t op1_p;
   word_t op2_p;
   alu_op_t op_p;

   // stage two
   alu_op_t op_pp;
   word_t add_pp;
   word_t sub_pp;
   word_t xor_pp;
   word_t or_pp;
   word_t and_pp;
   word_t sll_pp;
   word_t srl_pp;
   word_t sra_pp;
   logic sh16_pp;      // shift amount bit 4
   logic slt_hi_pp;
   logic sltu_hi_pp;
   logic hi_eq_pp;
   logic lt_lo_pp;     // low halves, always unsigned

   always_ff @(posedge i_clk) begin
      op1_p <= i_op1;
      op2_p <= i_req.use_imm ? i_req.imm : i_op2;
      op_p <= i_req.op;
   end

   always_ff @(posedge i_clk) begin
      op_pp <= op_p;
      add_pp <= op1_p + op2_p;
      sub_pp <= op1_p - op2_p;
      xor_pp <= op1_p ^ op2_p;
      or_pp <= op1_p | op2_p;
      and_pp <= op1_p & op2_p;

      // low four bits here, the 16 step is done at the output mux
      sll_pp <= op1_p << op2_p[3:0];
      srl_pp <= op1_p >> op2_p[3:0];
      sra_pp <= $signed(op1_p) >>> op2_p[3:0];
      sh16_pp <= op2_p[4];

      slt_hi_pp <= $signed(op1_p[31:16]) < $signed(op2_p[31:16]);
      sltu_hi_pp <= op1_p[31:16] < op2_p[31:16];
      hi_eq_pp <= op1_p[31:16] == op2_p[31:16];
      lt_lo_pp <= op1_p[15:0] < op2_p[15:0];
   end

   always_comb begin
      case (op_pp)
         ALU_ADD: o_result = add_pp;
         ALU_SUB: o_result = sub_pp;
         ALU_SLL: o_result = sh16_pp ? {sll_pp[15:0], 16'b0} : sll_pp;
         ALU_SRL: o_result = sh16_pp ? {16'b0, srl_pp[31:16]} : srl_pp;
         ALU_SRA: begin
            o_result = sh16_pp ? {{16{sra_pp[31]}}, sra_pp[31:16]} : sra_pp;
         end
         // low halves decide only on a high-half tie
         ALU_SLT: o_result = {31'b0, hi_eq_pp ? lt_lo_pp : slt_hi_pp};
         ALU_SLTU: o_result = {31'b0, hi_eq_pp ? lt_lo_pp : sltu_hi_pp};
         ALU_XOR: o_result = xor_pp;
         ALU_OR: o_result = or_pp;
         ALU_AND: o_result = and_pp;
         default: o_result = add_pp;
      endcase
   end

endmodule

// File: verilog/rv_decoder.sv
// combinational decoder for LUI, OP and OP-IMM only; anything else is flagged illegal
`timescale 1ns/100ps

module rv_decoder (
   input  rv_pkg::inst_t     i_inst,
   output rv_pkg::reg_addr_t o_rs1,
   output rv_pkg::reg_addr_t o_rs2,
   output rv_pkg::reg_addr_t o_rd,
   output rv_pkg::alu_req_t  o_alu_req,
   output logic              o_illegal
);
   import rv_pkg::*;

   logic [4:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   word_t imm_i;
   word_t imm_u;

   assign opcode = i_inst[6:2];
   assign funct3 = i_inst[14:12];
   assign funct7 = i_inst[31:25];

   assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
   assign imm_u = {i_inst[31:12], 12'b0};

   always_comb begin
      o_rs1 = i_inst[19:15];
      o_rs2 = i_inst[24:20];
      o_rd = i_inst[11:7];
      o_alu_req.op = ALU_ADD;
      o_alu_req.use_imm = 1'b0;
      o_alu_req.imm = imm_i;
      o_illegal = 1'b0;

      if (i_inst[1:0] != 2'b11) begin // compressed or reserved
         o_illegal = 1'b1;
      end else begin
         case (opcode)
            OPC_LUI: begin
               // x0 + imm
               o_rs1 = '0;
               o_alu_req.use_imm = 1'b1;
               o_alu_req.imm = imm_u;
            end

            OPC_OP: begin
               o_alu_req.op = alu_op_t'({funct7[5], funct3});
               if (funct7 == F7_ALT) begin
                  // only sub and sra take the alternate funct7
                  o_illegal = (funct3 != F3_ADD) && (funct3 != F3_SR);
               end else begin
                  o_illegal = (funct7 != F7_BASE);
               end
            end

            OPC_OPIMM: begin
               // bit 3 only meaningful for srai
               o_alu_req.op = alu_op_t'({(funct3 == F3_SR) & funct7[5], funct3});
               o_alu_req.use_imm = 1'b1;
               if (funct3 == F3_SLL) begin
                  o_illegal = (funct7 != F7_BASE);
               end else if (funct3 == F3_SR) begin
                  o_illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
               end
            end

            default: begin
               o_illegal = 1'b1;
            end
         endcase
      end
   end

endmodule

// File: verilog/rv_exec_top.sv
// execute slice top; no stall, no interlock, issuer keeps dependent ops three cycles apart
`timescale 1ns/100ps

module rv_exec_top (
   input  logic          i_clk,
   input  logic          i_rst,
   input  logic          i_valid,
   input  rv_pkg::inst_t i_inst,
   output rv_pkg::wb_t   o_wb
);
   import rv_pkg::*;

   reg_addr_t rs1;
   reg_addr_t rs2;
   reg_addr_t rd;
   logic illegal;
   alu_req_t alu_req;
   alu_req_t alu_req_d;
   wb_tag_t tag;
   wb_tag_t tag_d;
   word_t op1;
   word_t op2;
   word_t result;

   rv_decoder i_rv_decoder (
      .i_inst    (i_inst),
      .o_rs1     (rs1),
      .o_rs2     (rs2),
      .o_rd      (rd),
      .o_alu_req (alu_req),
      .o_illegal (illegal)
   );

   // illegal only means something on an issue slot
   assign tag = '{valid: i_valid, illegal: i_valid && illegal, rd: rd};

   // lines the request up with the operands
   stage_delay #(.DEPTH(OPERAND_LATENCY), .T(alu_req_t)) i_req_delay (
      .i_clk (i_clk),
      .i_rst (i_rst),
      .i_d   (alu_req),
      .o_q   (alu_req_d)
   );

   stage_delay #(.DEPTH(WB_LATENCY), .T(wb_tag_t)) i_tag_delay (
      .i_clk (i_clk),
      .i_rst (i_rst),
      .i_d   (tag),
      .o_q   (tag_d)
   );

   rv_regfile i_rv_regfile (
      .i_clk (i_clk),
      .i_rs1 (rs1),
      .i_rs2 (rs2),
      .i_wb  (o_wb),
      .o_op1 (op1),
      .o_op2 (op2)
   );

   rv_alu i_rv_alu (
      .i_clk    (i_clk),
      .i_op1    (op1),
      .i_op2    (op2),
      .i_req    (alu_req_d),
      .o_result (result)
   );

   // result goes out and back into the regfile in the same cycle
   assign o_wb = '{valid: tag_d.valid, illegal: tag_d.illegal, rd: tag_d.rd, data: result};

endmodule

// File: verilog/rv_pkg.sv
// shared widths, opcodes and structs for the RV32I execute slice; only LUI, OP and OP-IMM exist
package rv_pkg;

   localparam int XLEN = 32;
   localparam int NREGS = 32;

   typedef logic [XLEN-1:0] word_t;
   typedef logic [$clog2(NREGS)-1:0] reg_addr_t;
   typedef logic [31:0] inst_t;

   // major opcodes, instruction bits 6..2
   localparam logic [4:0] OPC_LUI = 5'b01101;
   localparam logic [4:0] OPC_OP = 5'b01100;
   localparam logic [4:0] OPC_OPIMM = 5'b00100;

   // funct fields the decoder checks
   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_SLL = 3'b001;
   localparam logic [2:0] F3_SR = 3'b101;
   localparam logic [6:0] F7_BASE = 7'h00;
   localparam logic [6:0] F7_ALT = 7'h20;

   // encoded as {funct7[5], funct3}
   typedef enum logic [3:0] {
      ALU_ADD = 4'b0000,
      ALU_SUB = 4'b1000,
      ALU_SLL = 4'b0001,
      ALU_SLT = 4'b0010,
      ALU_SLTU = 4'b0011,
      ALU_XOR = 4'b0100,
      ALU_SRL = 4'b0101,
      ALU_SRA = 4'b1101,
      ALU_OR = 4'b0110,
      ALU_AND = 4'b0111
   } alu_op_t;

   // request to the ALU, travels alongside the operand read
   typedef struct packed {
      alu_op_t op;
      logic use_imm; // operand 2 from imm, not rs2
      word_t imm;
   } alu_req_t;

   // writeback bookkeeping, rides the long delay line
   typedef struct packed {
      logic valid;
      logic illegal;
      reg_addr_t rd;
   } wb_tag_t;

   // result leaving the slice, also the regfile write port
   typedef struct packed {
      logic valid;
      logic illegal;
      reg_addr_t rd;
      word_t data;
   } wb_t;

   // register file read delay
   localparam int OPERAND_LATENCY = 1;

   // issue to result, regfile read plus two ALU stages
   localparam int WB_LATENCY = 3;

endpackage

// File: verilog/rv_regfile.sv
// 32x32 regfile, one cycle registered read, x0 reads zero; contents are not reset
`timescale 1ns/100ps

module rv_regfile (
   input  logic              i_clk,
   input  rv_pkg::reg_addr_t i_rs1,
   input  rv_pkg::reg_addr_t i_rs2,
   input  rv_pkg::wb_t       i_wb,
   output rv_pkg::word_t     o_op1,
   output rv_pkg::word_t     o_op2
);
   import rv_pkg::*;

   word_t mem [NREGS];

   logic wr_en;
   logic wr_en_q;
   reg_addr_t wr_rd_q;
   word_t wr_data_q;
   word_t op1_q;
   word_t op2_q;

   // illegal results and x0 never reach the array
   assign wr_en = i_wb.valid && !i_wb.illegal && (i_wb.rd != '0);

   // array write lags a cycle, the two bypass levels hide that
   function automatic word_t read_port(reg_addr_t rs);
      word_t val;
      if (rs == '0) begin
         val = '0;
      end else if (wr_en && (i_wb.rd == rs)) begin
         val = i_wb.data;
      end else if (wr_en_q && (wr_rd_q == rs)) begin
         val = wr_data_q;
      end else begin
         val = mem[rs];
      end
      return val;
   endfunction

   always_ff @(posedge i_clk) begin
      wr_en_q <= wr_en;
      wr_rd_q <= i_wb.rd;
      wr_data_q <= i_wb.data;
      if (wr_en_q) begin
         mem[wr_rd_q] <= wr_data_q;
      end

      op1_q <= read_port(i_rs1);
      op2_q <= read_port(i_rs2);
   end

   assign o_op1 = op1_q;
   assign o_op2 = op2_q;

endmodule

// File: verilog/stage_delay.sv
// fixed delay line for any packed payload, DEPTH of at least 1, clears to zero on reset
`timescale 1ns/100ps

module stage_delay #(
   parameter int DEPTH = 1,
   parameter type T = logic
) (
   input  logic i_clk,
   input  logic i_rst,
   input  T     i_d,
   output T     o_q
);

   T pipe [DEPTH];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < DEPTH; i++) begin
            pipe[i] <= '0;
         end
      end else begin
         pipe[0] <= i_d;
         for (int i = 1; i < DEPTH; i++) begin
            pipe[i] <= pipe[i-1];
         end
      end
   end

   assign o_q = pipe[DEPTH-1];

endmodule
